// ==== project.f ====
+incdir+.
rv_core_pkg.sv
pipe_ctrl_if.sv
pipe_ctrl.sv
inst_rom.sv
if_stage.sv
if_id.sv
id_stage.sv
rv_frontend_top.sv
frontend_scoreboard.sv
frontend_chk.sv
tb_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) rv_core_params.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "simulation passed" || \
	  (echo "simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_frontend.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module tb_frontend;
  import rv_core_pkg::*;

  logic        clk = 1'b0;
  logic        reset;
  logic        stall_req;
  logic        redirect_valid;
  xlen_t       redirect_addr;
  logic        rom_we;
  rom_addr_t   rom_waddr;
  inst_t       rom_wdata;
  ctrl_bus_t   stall_bus;
  ctrl_bus_t   flush_bus;
  xlen_t       id_pc;
  logic [6:0]  id_opcode;
  logic [4:0]  id_rd;
  logic [4:0]  id_rs1;
  logic [4:0]  id_rs2;
  xlen_t       id_imm;
  trap_t       id_trap;
  int unsigned check_count;
  int unsigned error_count;

  always #10 clk = ~clk;

  rv_frontend_top rv_frontend_top_inst (
    .clk              (clk),
    .reset_i          (reset),
    .stall_req_id_i   (stall_req),
    .redirect_valid_i (redirect_valid),
    .redirect_addr_i  (redirect_addr),
    .rom_we_i         (rom_we),
    .rom_waddr_i      (rom_waddr),
    .rom_wdata_i      (rom_wdata),
    .stall_bus_o      (stall_bus),
    .flush_bus_o      (flush_bus),
    .id_pc_o          (id_pc),
    .id_opcode_o      (id_opcode),
    .id_rd_o          (id_rd),
    .id_rs1_o         (id_rs1),
    .id_rs2_o         (id_rs2),
    .id_imm_o         (id_imm),
    .id_trap_o        (id_trap)
  );

  frontend_scoreboard u_scoreboard (
    .clk_i            (clk),
    .reset_i          (reset),
    .stall_req_id_i   (stall_req),
    .redirect_valid_i (redirect_valid),
    .redirect_addr_i  (redirect_addr),
    .rom_we_i         (rom_we),
    .rom_waddr_i      (rom_waddr),
    .rom_wdata_i      (rom_wdata),
    .stall_bus_i      (stall_bus),
    .flush_bus_i      (flush_bus),
    .id_pc_i          (id_pc),
    .id_opcode_i      (id_opcode),
    .id_rd_i          (id_rd),
    .id_rs1_i         (id_rs1),
    .id_rs2_i         (id_rs2),
    .id_imm_i         (id_imm),
    .id_trap_i        (id_trap),
    .check_count_o    (check_count),
    .error_count_o    (error_count)
  );

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  function automatic xlen_t pick_target();
    int unsigned kind;
    xlen_t       target;
    kind   = $urandom % 10;
    target = `RV_PC_RESET_ADDR + 64'(4 * ($urandom % `RV_ROM_WORDS));
    if (kind == 8) begin
      target = target + 64'(1 + $urandom % 3);                      // misaligned.
    end else if (kind == 9 && ($urandom % 2) == 0) begin
      target = `RV_PC_RESET_ADDR + 64'(4 * (`RV_ROM_WORDS + $urandom % 64));
    end else if (kind == 9) begin
      target = `RV_PC_RESET_ADDR - 64'(16 + 4 * ($urandom % 32));   // below the rom.
    end
    return target;
  endfunction

  task automatic load_rom();
    inst_t word;
    for (int i = 0; i < `RV_ROM_WORDS; i++) begin
      @(negedge clk);
      word = $urandom;
      if ($urandom % 6 != 0) begin
        word[1:0] = 2'b11;
      end
      rom_we    = 1'b1;
      rom_waddr = rom_addr_t'(i);
      rom_wdata = word;
    end
    @(negedge clk);
    rom_we = 1'b0;
  endtask

  // restart fetch at the reset address and wait for it to reach decode.
  task automatic restart_fetch(output bit restarted);
    int unsigned waited;
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_addr  = `RV_PC_RESET_ADDR;
    @(negedge clk);
    redirect_valid = 1'b0;
    waited = 0;
    while (id_pc != `RV_PC_RESET_ADDR && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    restarted = (id_pc == `RV_PC_RESET_ADDR);
  endtask

  task automatic drive_random_cycles(input int unsigned cycles);
    for (int unsigned n = 0; n < cycles; n++) begin
      @(negedge clk);
      stall_req      = ($urandom % 4) == 0;
      redirect_valid = ($urandom % 10) == 0;
      redirect_addr  = redirect_valid ? pick_target() : '0;
    end
    @(negedge clk);
    stall_req      = 1'b0;
    redirect_valid = 1'b0;
  endtask

  task automatic report_result();
    int unsigned assert_fails;
    assert_fails = rv_frontend_top_inst.u_if_id.u_frontend_chk.assert_fail_count;
    $display("compares %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    bit restarted;
    void'($urandom(32'h3d1b_3805));
    reset          = 1'b1;
    stall_req      = 1'b0;
    redirect_valid = 1'b0;
    redirect_addr  = '0;
    rom_we         = 1'b0;
    rom_waddr      = '0;
    rom_wdata      = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    load_rom();                          // fetch runs through the rom meanwhile.
    restart_fetch(restarted);
    if (restarted) begin
      repeat (20) @(negedge clk);        // plain sequential fetch.
      drive_random_cycles(1500);
      repeat (4) @(negedge clk);
      report_result();
    end else begin
      $display("timeout: fetch never restarted at the reset address");
      $display("Checks failed");
      $finish;
    end
  end

endmodule

// ==== frontend_chk.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module frontend_chk (
  input logic                   clk_i,
  input logic                   reset_i,
  input rv_core_pkg::ctrl_bus_t stall_bus_i,
  input rv_core_pkg::ctrl_bus_t flush_bus_i,
  input rv_core_pkg::xlen_t     pc_i,
  input rv_core_pkg::inst_t     inst_i,
  input rv_core_pkg::trap_t     trap_i
);
  import rv_core_pkg::*;

  int unsigned assert_fail_count = 0;

  ////////////////////////////////////////
  // control bus rules
  ////////////////////////////////////////
  a_redirect_no_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_bus_i[`RV_CTRL_IF_ID] |-> (stall_bus_i == '0))
    else begin
      assert_fail_count++;
      $error("stall bits set while a redirect flushes IF/ID");
    end

  a_flush_chain: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_bus_i[`RV_CTRL_IF_ID] |-> flush_bus_i[`RV_CTRL_ID_EX])
    else begin
      assert_fail_count++;
      $error("IF/ID flush without ID/EX flush");
    end

  // stage register holds a bubble right after reset.
  a_reset_values: assert property (@(posedge clk_i)
    reset_i |=> (pc_i == '0 && inst_i == `RV_INST_NOP && trap_i == '0))
    else begin
      assert_fail_count++;
      $error("IF/ID outputs differ from their reset values");
    end

endmodule

bind if_id frontend_chk u_frontend_chk (
  .clk_i       (clk),
  .reset_i     (reset_i),
  .stall_bus_i (stall_valid_i),
  .flush_bus_i (flush_valid_i),
  .pc_i        (inst_addr_if_id_o),
  .inst_i      (inst_data_if_id_o),
  .trap_i      (trap_bus_if_id_o)
);

// ==== frontend_scoreboard.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module frontend_scoreboard (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   stall_req_id_i,
  input  logic                   redirect_valid_i,
  input  rv_core_pkg::xlen_t     redirect_addr_i,
  input  logic                   rom_we_i,
  input  rv_core_pkg::rom_addr_t rom_waddr_i,
  input  rv_core_pkg::inst_t     rom_wdata_i,
  input  rv_core_pkg::ctrl_bus_t stall_bus_i,
  input  rv_core_pkg::ctrl_bus_t flush_bus_i,
  input  rv_core_pkg::xlen_t     id_pc_i,
  input  logic [6:0]             id_opcode_i,
  input  logic [4:0]             id_rd_i,
  input  logic [4:0]             id_rs1_i,
  input  logic [4:0]             id_rs2_i,
  input  rv_core_pkg::xlen_t     id_imm_i,
  input  rv_core_pkg::trap_t     id_trap_i,
  output int unsigned            check_count_o,
  output int unsigned            error_count_o
);
  import rv_core_pkg::*;

  xlen_t model_pc;
  xlen_t hold_pc;                       // model of the IF/ID register.
  inst_t hold_inst;
  trap_t hold_trap;
  inst_t model_rom [`RV_ROM_WORDS];

  initial begin
    check_count_o = 0;
    error_count_o = 0;
  end

  task automatic compare_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    check_count_o++;
    if (act_val !== exp_val) begin
      error_count_o++;
      $display("Fail %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  ////////////////////////////////////////
  // expected outputs from the model state
  ////////////////////////////////////////
  task automatic compare_outputs();
    ctrl_bus_t exp_stall;
    ctrl_bus_t exp_flush;
    trap_t     exp_trap;
    exp_stall = '0;
    exp_flush = '0;
    if (redirect_valid_i) begin
      exp_flush[`RV_CTRL_IF_ID] = 1'b1;
      exp_flush[`RV_CTRL_ID_EX] = 1'b1;
    end else if (stall_req_id_i) begin
      exp_stall[`RV_CTRL_PC]    = 1'b1;
      exp_stall[`RV_CTRL_IF_ID] = 1'b1;
      exp_flush[`RV_CTRL_ID_EX] = 1'b1;
    end
    exp_trap = hold_trap;
    if (hold_trap == '0 && hold_inst[1:0] != 2'b11) begin
      exp_trap[`RV_TRAP_ILLEGAL] = 1'b1;  // compressed encodings are not supported.
    end
    compare_value("stall bus", 64'(exp_stall), 64'(stall_bus_i));
    compare_value("flush bus", 64'(exp_flush), 64'(flush_bus_i));
    compare_value("decode pc", hold_pc, id_pc_i);
    compare_value("decode opcode", 64'(hold_inst[6:0]), 64'(id_opcode_i));
    compare_value("decode rd", 64'(hold_inst[11:7]), 64'(id_rd_i));
    compare_value("decode rs1", 64'(hold_inst[19:15]), 64'(id_rs1_i));
    compare_value("decode rs2", 64'(hold_inst[24:20]), 64'(id_rs2_i));
    compare_value("decode imm", 64'($signed(hold_inst[31:20])), id_imm_i);
    compare_value("decode trap", 64'(exp_trap), 64'(id_trap_i));
  endtask

  task automatic advance_model();
    logic  in_rom;
    trap_t fetch_trap;
    inst_t fetch_inst;
    in_rom = (model_pc >= `RV_PC_RESET_ADDR) &&
             (model_pc < `RV_PC_RESET_ADDR + 64'(4 * `RV_ROM_WORDS));
    fetch_trap = '0;
    fetch_trap[`RV_TRAP_FETCH_MISALIGN] = model_pc[1:0] != 2'b00;
    fetch_trap[`RV_TRAP_FETCH_FAULT]    = !in_rom;
    fetch_inst = `RV_INST_NOP;
    if (fetch_trap == '0) begin
      fetch_inst = model_rom[rom_addr_t'((model_pc - `RV_PC_RESET_ADDR) >> 2)];
    end
    if (redirect_valid_i || !stall_req_id_i) begin
      if (redirect_valid_i || model_pc == `RV_PC_RESET_ADDR - 64'd4) begin
        hold_pc   = '0;
        hold_inst = `RV_INST_NOP;
        hold_trap = '0;
      end else begin
        hold_pc   = model_pc;
        hold_inst = fetch_inst;
        hold_trap = fetch_trap;
      end
    end
    if (redirect_valid_i) begin
      model_pc = redirect_addr_i;
    end else if (!stall_req_id_i) begin
      model_pc = model_pc + 64'd4;
    end
    // a write lands after this cycle's read.
    if (rom_we_i) begin
      model_rom[rom_waddr_i] = rom_wdata_i;
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      model_pc  = `RV_PC_RESET_ADDR - 64'd4;
      hold_pc   = '0;
      hold_inst = `RV_INST_NOP;
      hold_trap = '0;
      for (int i = 0; i < `RV_ROM_WORDS; i++) begin
        model_rom[i] = `RV_INST_NOP;
      end
    end else begin
      compare_outputs();
      advance_model();
    end
  end

endmodule

// ==== rv_frontend_top.sv ====
`timescale 1ns/1ns

module rv_frontend_top (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   stall_req_id_i,
  input  logic                   redirect_valid_i,
  input  rv_core_pkg::xlen_t     redirect_addr_i,
  input  logic                   rom_we_i,
  input  rv_core_pkg::rom_addr_t rom_waddr_i,
  input  rv_core_pkg::inst_t     rom_wdata_i,
  output rv_core_pkg::ctrl_bus_t stall_bus_o,
  output rv_core_pkg::ctrl_bus_t flush_bus_o,
  output rv_core_pkg::xlen_t     id_pc_o,
  output logic [6:0]             id_opcode_o,
  output logic [4:0]             id_rd_o,
  output logic [4:0]             id_rs1_o,
  output logic [4:0]             id_rs2_o,
  output rv_core_pkg::xlen_t     id_imm_o,
  output rv_core_pkg::trap_t     id_trap_o
);
  import rv_core_pkg::*;

  xlen_t inst_addr_if;
  inst_t inst_data_if;
  trap_t trap_bus_if;
  xlen_t inst_addr_if_id;
  inst_t inst_data_if_id;
  trap_t trap_bus_if_id;

  pipe_ctrl_if ctrl_bus ();

  pipe_ctrl u_pipe_ctrl (
    .stall_req_id_i   (stall_req_id_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_addr_i  (redirect_addr_i),
    .ctrl             (ctrl_bus.ctrl)
  );

  ////////////////////////////////////////
  // fetch, stage register, decode
  ////////////////////////////////////////
  if_stage u_if_stage (
    .clk         (clk),
    .reset_i     (reset_i),
    .ctrl        (ctrl_bus.fetch),
    .rom_we_i    (rom_we_i),
    .rom_waddr_i (rom_waddr_i),
    .rom_wdata_i (rom_wdata_i),
    .inst_addr_o (inst_addr_if),
    .inst_data_o (inst_data_if),
    .trap_bus_o  (trap_bus_if)
  );

  if_id u_if_id (
    .clk               (clk),
    .reset_i           (reset_i),
    .stall_valid_i     (ctrl_bus.stage.stall),
    .flush_valid_i     (ctrl_bus.stage.flush),
    .inst_addr_if_i    (inst_addr_if),
    .inst_data_if_i    (inst_data_if),
    .trap_bus_if_i     (trap_bus_if),
    .inst_addr_if_id_o (inst_addr_if_id),
    .inst_data_if_id_o (inst_data_if_id),
    .trap_bus_if_id_o  (trap_bus_if_id)
  );

  id_stage u_id_stage (
    .inst_addr_i (inst_addr_if_id),
    .inst_data_i (inst_data_if_id),
    .trap_bus_i  (trap_bus_if_id),
    .pc_o        (id_pc_o),
    .opcode_o    (id_opcode_o),
    .rd_o        (id_rd_o),
    .rs1_o       (id_rs1_o),
    .rs2_o       (id_rs2_o),
    .imm_i_o     (id_imm_o),
    .trap_bus_o  (id_trap_o)
  );

  // later stages live outside, they take their bits from here.
  assign stall_bus_o = ctrl_bus.stall;
  assign flush_bus_o = ctrl_bus.flush;

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module id_stage (
  input  rv_core_pkg::xlen_t inst_addr_i,
  input  rv_core_pkg::inst_t inst_data_i,
  input  rv_core_pkg::trap_t trap_bus_i,
  output rv_core_pkg::xlen_t pc_o,
  output logic [6:0]         opcode_o,
  output logic [4:0]         rd_o,
  output logic [4:0]         rs1_o,
  output logic [4:0]         rs2_o,
  output rv_core_pkg::xlen_t imm_i_o,
  output rv_core_pkg::trap_t trap_bus_o
);
  import rv_core_pkg::*;

  logic  illegal;
  trap_t trap_bus;

  ////////////////////////////////////////
  // field split
  ////////////////////////////////////////
  assign pc_o     = inst_addr_i;
  assign opcode_o = inst_data_i[6:0];
  assign rd_o     = inst_data_i[11:7];
  assign rs1_o    = inst_data_i[19:15];
  assign rs2_o    = inst_data_i[24:20];

  // i-type immediate, sign bit is inst[31].
  assign imm_i_o = {{(`RV_XLEN - 12){inst_data_i[31]}}, inst_data_i[31:20]};

  ////////////////////////////////////////
  // illegal instruction
  ////////////////////////////////////////
  // only 32-bit encodings are supported, compressed ones are illegal.
  // A fetch trap already carries a nop, so it wins over this check.
  assign illegal = (inst_data_i[1:0] != 2'b11) && (trap_bus_i == '0);

  always_comb begin
    trap_bus = trap_bus_i;
    if (illegal) begin
      trap_bus[`RV_TRAP_ILLEGAL] = 1'b1;
    end
  end

  assign trap_bus_o = trap_bus;

endmodule

// ==== if_id.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module if_id (
  input  logic                   clk,
  input  logic                   reset_i,
  input  rv_core_pkg::ctrl_bus_t stall_valid_i,  // hold current data.
  input  rv_core_pkg::ctrl_bus_t flush_valid_i,  // load a nop bubble.
  input  rv_core_pkg::xlen_t     inst_addr_if_i,
  input  rv_core_pkg::inst_t     inst_data_if_i,
  input  rv_core_pkg::trap_t     trap_bus_if_i,
  output rv_core_pkg::xlen_t     inst_addr_if_id_o,
  output rv_core_pkg::inst_t     inst_data_if_id_o,
  output rv_core_pkg::trap_t     trap_bus_if_id_o
);

  logic reg_wen;
  logic bubble;

  assign reg_wen = ~stall_valid_i[`RV_CTRL_IF_ID];

  // the pre-reset pc never carries a real instruction.
  assign bubble = flush_valid_i[`RV_CTRL_IF_ID] |
                  (inst_addr_if_i == `RV_PC_RESET_ADDR - 64'd4);

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      inst_addr_if_id_o <= '0;
      inst_data_if_id_o <= `RV_INST_NOP;
      trap_bus_if_id_o  <= '0;
    end else if (reg_wen) begin
      if (bubble) begin
        inst_addr_if_id_o <= '0;
        inst_data_if_id_o <= `RV_INST_NOP;
        trap_bus_if_id_o  <= '0;
      end else begin
        inst_addr_if_id_o <= inst_addr_if_i;
        inst_data_if_id_o <= inst_data_if_i;
        trap_bus_if_id_o  <= trap_bus_if_i;
      end
    end
  end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module if_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  pipe_ctrl_if.fetch             ctrl,
  input  logic                   rom_we_i,
  input  rv_core_pkg::rom_addr_t rom_waddr_i,
  input  rv_core_pkg::inst_t     rom_wdata_i,
  output rv_core_pkg::xlen_t     inst_addr_o,
  output rv_core_pkg::inst_t     inst_data_o,
  output rv_core_pkg::trap_t     trap_bus_o
);
  import rv_core_pkg::*;

  xlen_t     pc_q;
  xlen_t     pc_next;
  xlen_t     pc_offset;
  rom_addr_t rom_raddr;
  inst_t     rom_rdata;
  trap_t     trap_bus;

  ////////////////////////////////////////
  // program counter
  ////////////////////////////////////////
  always_comb begin
    if (ctrl.redirect_valid) begin
      pc_next = ctrl.redirect_addr;
    end else if (ctrl.stall[`RV_CTRL_PC]) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_q + xlen_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= `RV_PC_RESET_ADDR - 64'd4;  // first increment lands on reset addr.
    end else begin
      pc_q <= pc_next;
    end
  end

  ////////////////////////////////////////
  // rom lookup and fetch traps
  ////////////////////////////////////////
  assign pc_offset = pc_q - `RV_PC_RESET_ADDR;  // wraps high when below the rom.
  assign rom_raddr = pc_offset[`RV_ROM_AW+1:2];

  inst_rom u_inst_rom (
    .clk     (clk),
    .reset_i (reset_i),
    .we_i    (rom_we_i),
    .waddr_i (rom_waddr_i),
    .wdata_i (rom_wdata_i),
    .raddr_i (rom_raddr),
    .rdata_o (rom_rdata)
  );

  always_comb begin
    trap_bus = '0;
    trap_bus[`RV_TRAP_FETCH_MISALIGN] = |pc_q[1:0];
    trap_bus[`RV_TRAP_FETCH_FAULT]    = pc_offset >= xlen_t'(4 * `RV_ROM_WORDS);
  end

  assign inst_addr_o = pc_q;
  assign inst_data_o = (|trap_bus) ? `RV_INST_NOP : rom_rdata;
  assign trap_bus_o  = trap_bus;

endmodule

// ==== inst_rom.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module inst_rom (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   we_i,
  input  rv_core_pkg::rom_addr_t waddr_i,
  input  rv_core_pkg::inst_t     wdata_i,
  input  rv_core_pkg::rom_addr_t raddr_i,
  output rv_core_pkg::inst_t     rdata_o
);
  import rv_core_pkg::*;

  inst_t mem [`RV_ROM_WORDS];

  ////////////////////////////////////////
  // boot-load write port
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `RV_ROM_WORDS; i++) begin
        mem[i] <= `RV_INST_NOP;          // empty rom reads as nop.
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // combinational read, fetch sees it in the same cycle.
  assign rdata_o = mem[raddr_i];

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module pipe_ctrl (
  input  logic               stall_req_id_i,
  input  logic               redirect_valid_i,
  input  rv_core_pkg::xlen_t redirect_addr_i,
  pipe_ctrl_if.ctrl          ctrl
);
  import rv_core_pkg::*;

  ctrl_bus_t stall_bus;
  ctrl_bus_t flush_bus;

  ////////////////////////////////////////
  // priority: redirect, then stall
  ////////////////////////////////////////
  always_comb begin
    stall_bus = '0;
    flush_bus = '0;
    if (redirect_valid_i) begin
      // drop the two younger instructions on the wrong path.
      flush_bus[`RV_CTRL_IF_ID] = 1'b1;
      flush_bus[`RV_CTRL_ID_EX] = 1'b1;
    end else if (stall_req_id_i) begin
      stall_bus[`RV_CTRL_PC]    = 1'b1;
      stall_bus[`RV_CTRL_IF_ID] = 1'b1;
      flush_bus[`RV_CTRL_ID_EX] = 1'b1;  // bubble into execute.
    end
  end

  assign ctrl.stall = stall_bus;
  assign ctrl.flush = flush_bus;

  // fetch sees the redirect only through this block.
  assign ctrl.redirect_valid = redirect_valid_i;
  assign ctrl.redirect_addr  = redirect_addr_i;

endmodule

// ==== pipe_ctrl_if.sv ====
`timescale 1ns/1ns

interface pipe_ctrl_if;
  import rv_core_pkg::*;

  ctrl_bus_t stall;            // hold the stage, keep current data.
  ctrl_bus_t flush;            // load a bubble into the stage.
  logic      redirect_valid;
  xlen_t     redirect_addr;

  modport ctrl (
    output stall,
    output flush,
    output redirect_valid,
    output redirect_addr
  );

  modport fetch (
    input stall,
    input flush,
    input redirect_valid,
    input redirect_addr
  );

  modport stage (
    input stall,
    input flush
  );

endinterface

// ==== rv_core_pkg.sv ====
`include "rv_core_params.svh"

package rv_core_pkg;

  // address or data word.
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // one instruction word.
  typedef logic [`RV_INST_LEN-1:0] inst_t;

  // trap bits, see RV_TRAP_* for positions.
  typedef logic [`RV_TRAP_LEN-1:0] trap_t;

  // stall or flush bus, indexed by RV_CTRL_*.
  typedef logic [`RV_CTRL_LEN-1:0] ctrl_bus_t;

  // word address into the instruction array.
  typedef logic [`RV_ROM_AW-1:0] rom_addr_t;

endpackage

// ==== rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

////////////////////////////////////////
// data path widths
////////////////////////////////////////
`define RV_XLEN              64
`define RV_INST_LEN          32
`define RV_TRAP_LEN          3

`define RV_PC_RESET_ADDR     64'h8000_0000   // first fetched address.
`define RV_INST_NOP          32'h0000_0013   // addi x0, x0, 0.

////////////////////////////////////////
// trap bus bit positions
////////////////////////////////////////
`define RV_TRAP_FETCH_MISALIGN  0
`define RV_TRAP_FETCH_FAULT     1
`define RV_TRAP_ILLEGAL         2

////////////////////////////////////////
// stall / flush bus, one bit per stage
////////////////////////////////////////
`define RV_CTRL_LEN          6
`define RV_CTRL_PC           0
`define RV_CTRL_IF_ID        1
`define RV_CTRL_ID_EX        2
`define RV_CTRL_EX_MEM       3
`define RV_CTRL_MEM_WB       4
`define RV_CTRL_WB           5

`define RV_ROM_WORDS         256
`define RV_ROM_AW            8             // log2 of the rom depth.

`endif
